//--- Makefile
TOP := sd_cmd_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- dv/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model import sd_cmd_pkg::*; (
  input  logic         sd_clk_i,
  input  logic         cmd_i,        // host drive
  input  logic         cmd_en_i,
  output logic         cmd_o,        // card drive, idles high
  input  rsp_type_e    rsp_type_i,
  input  logic [2:0]   mode_i,       // 0 normal, 1 bad crc, 2 bad end bit, 3 bad index, 4 silent
  input  logic [119:0] payload_i,
  input  logic [4:0]   delay_i,      // sd clocks from end bit to response start bit
  output int           frames_o,
  output logic [5:0]   index_o,
  output logic [31:0]  arg_o,
  output logic         crc_ok_o,
  output logic         dir_o,
  output logic         end_o
);

  logic [47:0] frame;

  // bitwise division by x^7 + x^3 + 1 over bits[n-1:0], msb first
  function automatic logic [6:0] crc7_calc(input logic [135:0] bits, input int n);
    logic [6:0] r;
    r = '0;
    for (int i = n - 1; i >= 0; i--) begin
      r = {r[5:0], 1'b0} ^ (((r[6] ^ bits[i]) == 1'b1) ? 7'h09 : 7'h00);
    end
    return r;
  endfunction

  task automatic answer(input logic [5:0] idx);
    logic [135:0] r;
    int           n;
    if (rsp_type_i == RSP_LONG) begin
      n = 136;
      r = {2'b00, (mode_i == 3'd3) ? 6'h15 : 6'h3f, payload_i, 8'h01};  // check field is ignored
      r[7:1] = crc7_calc({16'h0, payload_i}, 120);
    end else begin
      n = 48;
      r = {88'h0, 2'b00, (mode_i == 3'd3) ? ~idx : idx, payload_i[31:0], 8'h01};
      r[7:1] = crc7_calc({96'h0, r[47:8]}, 40);
    end
    if (mode_i == 3'd1) r[1] = ~r[1];
    if (mode_i == 3'd2) r[0] = 1'b0;
    repeat (delay_i) @(negedge sd_clk_i);
    for (int b = n - 1; b >= 0; b--) begin
      cmd_o = r[b];
      @(negedge sd_clk_i);
    end
    cmd_o = 1'b1;
  endtask

  // the host updates the line on the rising edge, so the card works mid-bit
  initial begin
    cmd_o    = 1'b1;
    frames_o = 0;
    forever begin
      @(negedge sd_clk_i);
      if (cmd_en_i && !cmd_i) begin
        frame[47] = 1'b0;
        for (int b = 46; b >= 0; b--) begin
          @(negedge sd_clk_i);
          frame[b] = cmd_i;
        end
        frames_o = frames_o + 1;
        index_o  = frame[45:40];
        arg_o    = frame[39:8];
        crc_ok_o = (crc7_calc({96'h0, frame[47:8]}, 40) == frame[7:1]);
        dir_o    = frame[46];
        end_o    = frame[0];
        if (rsp_type_i != RSP_NONE && mode_i != 3'd4) answer(frame[45:40]);
      end
    end
  end

endmodule

//--- dv/sd_cmd_tb.sv
`timescale 1ns/1ps

module sd_cmd_tb import sd_cmd_pkg::*; ();

  localparam int CLK_DIV        = 2;
  localparam int NUM_CMDS       = 60;
  localparam int TIMEOUT_CYCLES = 2000;

  logic         clk, rst_n, cmd_start, crc_check, index_check;
  logic [5:0]   cmd_index;
  logic [31:0]  cmd_arg;
  rsp_type_e    rsp_type;
  logic         busy, done, err_timeout, err_crc, err_end_bit, err_index;
  logic [119:0] rsp;
  logic         sd_clk, sd_cmd_in, sd_cmd_out, sd_cmd_en;
  logic [2:0]   card_mode;
  logic [119:0] card_payload;
  logic [4:0]   card_delay;
  int           frames;
  logic [5:0]   card_index;
  logic [31:0]  card_arg;
  logic         card_crc_ok, card_dir, card_end;
  int           errors, checks, en_cycles;
  bit           timed_out;

  sd_cmd_top #(.CLK_DIV(CLK_DIV)) UUT (
    .clk_i(clk), .rst_ni(rst_n), .cmd_start_i(cmd_start), .cmd_index_i(cmd_index),
    .cmd_arg_i(cmd_arg), .rsp_type_i(rsp_type), .crc_check_i(crc_check),
    .index_check_i(index_check), .busy_o(busy), .done_o(done), .rsp_o(rsp),
    .err_timeout_o(err_timeout), .err_crc_o(err_crc), .err_end_bit_o(err_end_bit),
    .err_index_o(err_index), .sd_clk_o(sd_clk), .sd_cmd_i(sd_cmd_in),
    .sd_cmd_o(sd_cmd_out), .sd_cmd_en_o(sd_cmd_en)
  );

  sd_card_model card (
    .sd_clk_i(sd_clk), .cmd_i(sd_cmd_out), .cmd_en_i(sd_cmd_en), .cmd_o(sd_cmd_in),
    .rsp_type_i(rsp_type), .mode_i(card_mode), .payload_i(card_payload),
    .delay_i(card_delay), .frames_o(frames), .index_o(card_index), .arg_o(card_arg),
    .crc_ok_o(card_crc_ok), .dir_o(card_dir), .end_o(card_end)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) if (sd_cmd_en) en_cycles++;  // cmd line drive time in clk cycles

  task automatic compare(input string name, input logic [119:0] got, input logic [119:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at time %0t: %s got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // one command, start to done

  task automatic run_command();
    logic [5:0]   idx;
    logic [31:0]  arg;
    logic [119:0] exp_rsp;
    logic         exp_to, exp_crc, exp_end, exp_idx;
    int           frames_before;
    int           wait_cnt;
    idx = 6'($urandom);
    arg = $urandom;
    @(posedge clk);
    #2;
    compare("busy_o", 120'(busy), 120'(0));
    cmd_index     = idx;
    cmd_arg       = arg;
    rsp_type      = rsp_type_e'(2'($urandom % 3));
    crc_check     = 1'($urandom);
    index_check   = 1'($urandom);
    card_mode     = 3'($urandom % 5);
    card_payload  = 120'({$urandom, $urandom, $urandom, $urandom});
    card_delay    = 5'(2 + $urandom % 19);
    frames_before = frames;
    en_cycles     = 0;
    cmd_start     = 1'b1;
    @(posedge clk);
    #2;
    cmd_start = 1'b0;
    compare("busy_o", 120'(busy), 120'(1));
    repeat (1 + $urandom % 40) @(posedge clk);
    #2;
    cmd_index = ~idx;  // start while busy, must not reach the card
    cmd_arg   = ~arg;
    cmd_start = 1'b1;
    @(posedge clk);
    #2;
    cmd_start = 1'b0;
    wait_cnt  = 0;
    while (done !== 1'b1 && wait_cnt < TIMEOUT_CYCLES) begin
      compare("busy_o", 120'(busy), 120'(1));
      @(posedge clk);
      #2;
      wait_cnt++;
    end
    assert (done === 1'b1) else begin
      errors++;
      timed_out = 1'b1;
      $display("done_o did not pulse within %0d cycles at time %0t", TIMEOUT_CYCLES, $time);
    end
    if (!timed_out) begin
      exp_rsp = '0;
      exp_to  = 1'b0;
      exp_crc = 1'b0;
      exp_end = 1'b0;
      exp_idx = 1'b0;
      if (rsp_type != RSP_NONE && card_mode == 3'd4) begin
        exp_to = 1'b1;
      end else if (rsp_type != RSP_NONE) begin
        exp_rsp = (rsp_type == RSP_LONG) ? card_payload : {88'h0, card_payload[31:0]};
        exp_crc = crc_check && card_mode == 3'd1;
        exp_end = card_mode == 3'd2;
        exp_idx = index_check && rsp_type == RSP_SHORT && card_mode == 3'd3;
      end
      compare("rsp_o", rsp, exp_rsp);
      compare("err_timeout_o", 120'(err_timeout), 120'(exp_to));
      compare("err_crc_o", 120'(err_crc), 120'(exp_crc));
      compare("err_end_bit_o", 120'(err_end_bit), 120'(exp_end));
      compare("err_index_o", 120'(err_index), 120'(exp_idx));
      compare("busy_o", 120'(busy), 120'(0));
      compare("sd_cmd_en_o", 120'(sd_cmd_en), 120'(0));
      compare("sd_cmd_en_o cycles", 120'(en_cycles), 120'(48 * 2 * CLK_DIV));
      compare("card frame count", 120'(frames - frames_before), 120'(1));
      compare("card index", 120'(card_index), 120'(idx));
      compare("card argument", 120'(card_arg), 120'(arg));
      compare("card crc ok", 120'(card_crc_ok), 120'(1));
      compare("card direction bit", 120'(card_dir), 120'(1));
      compare("card end bit", 120'(card_end), 120'(1));
    end
  endtask

  initial begin
    void'($urandom(32'he583_f750));
    rst_n        = 1'b0;
    cmd_start    = 1'b0;
    cmd_index    = '0;
    cmd_arg      = '0;
    rsp_type     = RSP_NONE;
    crc_check    = 1'b0;
    index_check  = 1'b0;
    card_mode    = '0;
    card_payload = '0;
    card_delay   = 5'd2;
    errors       = 0;
    checks       = 0;
    en_cycles    = 0;
    timed_out    = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int n = 0; n < NUM_CMDS && !timed_out; n++) run_command();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/sd_clk_gen.sv
`timescale 1ns/1ps

module sd_clk_gen #(
  parameter int unsigned CLK_DIV = 2  // clk_i cycles per sd clock half period
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic sd_clk_o,
  output logic clk_en_p_o   // high in the cycle before sd_clk_o rises
);

  localparam int unsigned CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [CNT_W-1:0] div_cnt_q;
  logic             sd_clk_q;
  logic             half_end;

  assign half_end = (div_cnt_q == CNT_W'(CLK_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      div_cnt_q <= '0;
      sd_clk_q  <= 1'b0;
    end else if (half_end) begin
      div_cnt_q <= '0;
      sd_clk_q  <= ~sd_clk_q;  // toggle once per half period
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  assign sd_clk_o   = sd_clk_q;
  assign clk_en_p_o = half_end & ~sd_clk_q;  // next toggle is a rising edge

  // even with CLK_DIV = 1 the strobe must leave a gap
  a_en_p_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clk_en_p_o |=> !clk_en_p_o);

endmodule

//--- rtl/sd_cmd_ifs.sv
`timescale 1ns/1ps

// sequencer to command writer
interface cmd_tx_if;
  logic        start;     // one clk_i cycle, on clk_en_p
  logic [5:0]  index;
  logic [31:0] argument;
  logic        done;      // after the end bit went out

  modport sequencer (output start, output index, output argument, input done);
  modport writer (input start, input index, input argument, output done);
endinterface

// sequencer to response reader
interface rsp_rx_if;
  logic         listen;      // level, hunt for a start bit while high
  logic         long_rsp;
  logic         receiving;
  logic         valid;       // one cycle strobe
  logic         end_bit_err;
  logic         crc_ok;
  logic [119:0] data;        // short: bits 39:8 in [31:0], long: bits 127:8

  modport sequencer (
    output listen, output long_rsp,
    input  receiving, input valid, input end_bit_err, input crc_ok, input data
  );
  modport reader (
    input  listen, input long_rsp,
    output receiving, output valid, output end_bit_err, output crc_ok, output data
  );
endinterface

//--- rtl/sd_cmd_pkg.sv
package sd_cmd_pkg;

  //////////////////////////////
  // types

  typedef enum logic [1:0] {
    RSP_NONE  = 2'd0,
    RSP_LONG  = 2'd1,  // 136 bit response (R2)
    RSP_SHORT = 2'd2   // 48 bit response
  } rsp_type_e;

  typedef enum logic [2:0] {
    READY,
    WRITE_CMD,
    BUS_SWITCH,    // two sd clocks of turnaround before listening
    READ_RSP,
    RSP_RECEIVED   // N_RC idle clocks before the next command
  } cmd_seq_state_e;

  //////////////////////////////
  // bus timing

  localparam int unsigned CMD_BITS      = 48;
  localparam int unsigned LONG_RSP_BITS = 136;
  localparam int unsigned NCR_TIMEOUT   = 64;  // sd clocks until a missing response is flagged
  localparam int unsigned N_RC          = 8;

  //////////////////////////////
  // crc7, x^7 + x^3 + 1, msb first

  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

endpackage

//--- rtl/sd_cmd_top.sv
`timescale 1ns/1ps

module sd_cmd_top import sd_cmd_pkg::*; #(
  parameter int unsigned CLK_DIV = 2
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         cmd_start_i,
  input  logic [5:0]   cmd_index_i,
  input  logic [31:0]  cmd_arg_i,
  input  rsp_type_e    rsp_type_i,
  input  logic         crc_check_i,
  input  logic         index_check_i,
  output logic         busy_o,
  output logic         done_o,
  output logic [119:0] rsp_o,
  output logic         err_timeout_o,
  output logic         err_crc_o,
  output logic         err_end_bit_o,
  output logic         err_index_o,
  output logic         sd_clk_o,
  input  logic         sd_cmd_i,
  output logic         sd_cmd_o,
  output logic         sd_cmd_en_o
);

  logic clk_en_p;

  cmd_tx_if tx_if ();
  rsp_rx_if rx_if ();

  sd_clk_gen #(
    .CLK_DIV (CLK_DIV)
  ) i_sd_clk_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sd_clk_o   (sd_clk_o),
    .clk_en_p_o (clk_en_p)
  );

  sd_cmd_write i_cmd_write (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clk_en_p_i (clk_en_p),
    .tx         (tx_if.writer),
    .cmd_o      (sd_cmd_o),
    .cmd_en_o   (sd_cmd_en_o)
  );

  sd_rsp_read i_rsp_read (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clk_en_p_i (clk_en_p),
    .cmd_i      (sd_cmd_i),
    .rx         (rx_if.reader)
  );

  sd_cmd_wrap i_cmd_wrap (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clk_en_p_i    (clk_en_p),
    .cmd_start_i   (cmd_start_i),
    .cmd_index_i   (cmd_index_i),
    .cmd_arg_i     (cmd_arg_i),
    .rsp_type_i    (rsp_type_i),
    .crc_check_i   (crc_check_i),
    .index_check_i (index_check_i),
    .tx            (tx_if.sequencer),
    .rx            (rx_if.sequencer),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .rsp_o         (rsp_o),
    .err_timeout_o (err_timeout_o),
    .err_crc_o     (err_crc_o),
    .err_end_bit_o (err_end_bit_o),
    .err_index_o   (err_index_o)
  );

endmodule

//--- rtl/sd_cmd_wrap.sv
`timescale 1ns/1ps

module sd_cmd_wrap import sd_cmd_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clk_en_p_i,
  input  logic              cmd_start_i,
  input  logic [5:0]        cmd_index_i,
  input  logic [31:0]       cmd_arg_i,
  input  rsp_type_e         rsp_type_i,
  input  logic              crc_check_i,
  input  logic              index_check_i,
  cmd_tx_if.sequencer       tx,
  rsp_rx_if.sequencer       rx,
  output logic              busy_o,
  output logic              done_o,
  output logic [119:0]      rsp_o,
  output logic              err_timeout_o,
  output logic              err_crc_o,
  output logic              err_end_bit_o,
  output logic              err_index_o
);

  cmd_seq_state_e state_q, state_d;

  logic [5:0]   cnt_q;          // ncr timeout and n_rc wait
  logic         timeout;
  logic         accept;
  logic         pend_q;         // accepted, writer not started yet
  logic         busy_q, done_q;
  logic [5:0]   index_q;
  logic [31:0]  arg_q;
  rsp_type_e    type_q;
  logic         crc_check_q, index_check_q;
  logic         err_to_q, err_crc_q, err_end_q, err_idx_q;
  logic [119:0] rsp_q;
  logic         rsp_end;        // leaving READ_RSP this strobe

  assign accept  = cmd_start_i & ~busy_q;
  assign rsp_end = (state_q == READ_RSP) && (state_d == RSP_RECEIVED);

  //////////////////////////////
  // state machine

  always_comb begin
    state_d = state_q;
    timeout = 1'b0;
    unique case (state_q)
      READY:        if (pend_q) state_d = WRITE_CMD;
      WRITE_CMD:    if (tx.done) state_d = (type_q == RSP_NONE) ? RSP_RECEIVED : BUS_SWITCH;
      BUS_SWITCH:   if (cnt_q == 6'd1) state_d = READ_RSP;
      READ_RSP: begin
        if (rx.valid) begin
          state_d = RSP_RECEIVED;
        end else if (!rx.receiving && cnt_q == 6'(NCR_TIMEOUT - 2)) begin
          timeout = 1'b1;  // no start bit within NCR
          state_d = RSP_RECEIVED;
        end
      end
      RSP_RECEIVED: if (cnt_q == 6'(N_RC - 1)) state_d = READY;
      default:      state_d = READY;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= READY;
      cnt_q   <= '0;
    end else if (clk_en_p_i) begin
      state_q <= state_d;
      if (state_d != state_q || (state_q == READ_RSP && rx.receiving)) cnt_q <= '0;
      else cnt_q <= cnt_q + 6'd1;
    end
  end

  //////////////////////////////
  // request and result

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q    <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      err_to_q  <= 1'b0;
      err_crc_q <= 1'b0;
      err_end_q <= 1'b0;
      err_idx_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q    <= 1'b1;
        pend_q    <= 1'b1;
        err_to_q  <= 1'b0;
        err_crc_q <= 1'b0;
        err_end_q <= 1'b0;
        err_idx_q <= 1'b0;
      end
      if (tx.start) pend_q <= 1'b0;
      if (clk_en_p_i && rsp_end) begin
        err_to_q  <= timeout;
        err_crc_q <= rx.valid & crc_check_q & ~rx.crc_ok;
        err_end_q <= rx.valid & rx.end_bit_err;
        err_idx_q <= rx.valid & index_check_q & (type_q == RSP_SHORT) &
                     (rx.data[37:32] != index_q);
      end
      if (clk_en_p_i && state_q == RSP_RECEIVED && state_d == READY) begin
        done_q <= 1'b1;
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      index_q       <= cmd_index_i;
      arg_q         <= cmd_arg_i;
      type_q        <= rsp_type_i;
      crc_check_q   <= crc_check_i;
      index_check_q <= index_check_i;
      rsp_q         <= '0;  // stays zero for RSP_NONE and timeouts
    end else if (clk_en_p_i && rsp_end && rx.valid) begin
      rsp_q <= (type_q == RSP_LONG) ? rx.data : {88'h0, rx.data[31:0]};
    end
  end

  assign tx.start    = clk_en_p_i & pend_q;
  assign tx.index    = index_q;
  assign tx.argument = arg_q;
  assign rx.listen   = (state_q == BUS_SWITCH) || (state_q == READ_RSP);
  assign rx.long_rsp = (type_q == RSP_LONG);

  assign busy_o        = busy_q;
  assign done_o        = done_q;
  assign rsp_o         = rsp_q;
  assign err_timeout_o = err_to_q;
  assign err_crc_o     = err_crc_q;
  assign err_end_bit_o = err_end_q;
  assign err_index_o   = err_idx_q;

  // writer has no back-pressure, a start must land in an idle sequencer
  a_start_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx.start |-> (state_q == READY));

endmodule

//--- rtl/sd_cmd_write.sv
`timescale 1ns/1ps

module sd_cmd_write import sd_cmd_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clk_en_p_i,
  cmd_tx_if.writer tx,
  output logic     cmd_o,
  output logic     cmd_en_o
);

  localparam int unsigned CRC_START = CMD_BITS - 8;  // first crc bit position

  logic [CMD_BITS-1:0] sr_q;       // frame, msb goes out first
  logic [5:0]          bit_cnt_q;
  logic [6:0]          crc_q;
  logic [6:0]          crc_d;
  logic                active_q;
  logic                tail_q;     // end bit is on the line
  logic                cmd_q;
  logic                cmd_en_q;

  assign crc_d = crc7_next(crc_q, sr_q[CMD_BITS-1]);

  //////////////////////////////
  // control

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      tail_q    <= 1'b0;
      cmd_q     <= 1'b1;
      cmd_en_q  <= 1'b0;
      bit_cnt_q <= '0;
      crc_q     <= '0;
    end else if (clk_en_p_i) begin
      tail_q <= 1'b0;
      if (tx.start) begin
        active_q  <= 1'b1;
        bit_cnt_q <= '0;
        crc_q     <= '0;
      end else if (active_q) begin
        cmd_q     <= sr_q[CMD_BITS-1];
        cmd_en_q  <= 1'b1;
        bit_cnt_q <= bit_cnt_q + 6'd1;
        if (bit_cnt_q < CRC_START) crc_q <= crc_d;  // crc over start..argument
        if (bit_cnt_q == 6'(CMD_BITS - 1)) begin
          active_q <= 1'b0;
          tail_q   <= 1'b1;
        end
      end else begin
        cmd_q    <= 1'b1;  // release, line idles high
        cmd_en_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // shift register

  always_ff @(posedge clk_i) begin
    if (clk_en_p_i) begin
      if (tx.start) begin
        sr_q <= {1'b0, 1'b1, tx.index, tx.argument, 7'h00, 1'b1};
      end else if (active_q) begin
        if (bit_cnt_q == 6'(CRC_START - 1)) begin
          // last argument bit leaves now, crc and end bit follow
          sr_q <= {crc_d, 1'b1, {(CMD_BITS - 8){1'b1}}};
        end else begin
          sr_q <= {sr_q[CMD_BITS-2:0], 1'b1};
        end
      end
    end
  end

  assign cmd_o    = cmd_q;
  assign cmd_en_o = cmd_en_q;
  assign tx.done  = tail_q & clk_en_p_i;

endmodule

//--- rtl/sd_rsp_read.sv
`timescale 1ns/1ps

module sd_rsp_read import sd_cmd_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clk_en_p_i,
  input  logic     cmd_i,
  rsp_rx_if.reader rx
);

  logic [7:0]   bit_cnt_q;    // position in the frame, start bit is 0
  logic [7:0]   frame_len;
  logic         receiving_q;
  logic         fin_q;        // frame complete, valid goes out next strobe
  logic [6:0]   crc_q;        // computed
  logic [6:0]   crc_rx_q;     // received
  logic [119:0] sh_q;
  logic         end_err_q;
  logic         crc_ok_q;
  logic         in_body;
  logic         in_crc_span;
  logic         is_end;
  logic         start_seen;

  assign frame_len = rx.long_rsp ? 8'(LONG_RSP_BITS) : 8'(CMD_BITS);
  assign in_body   = bit_cnt_q < (frame_len - 8'd8);
  assign is_end    = bit_cnt_q == (frame_len - 8'd1);

  // long responses skip start, direction and the 6 check bits
  assign in_crc_span = in_body && (!rx.long_rsp || bit_cnt_q >= 8'd8);

  assign start_seen = rx.listen && !receiving_q && !fin_q && !cmd_i;

  //////////////////////////////
  // control

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      receiving_q <= 1'b0;
      fin_q       <= 1'b0;
      bit_cnt_q   <= '0;
      crc_q       <= '0;
      end_err_q   <= 1'b0;
      crc_ok_q    <= 1'b0;
    end else if (clk_en_p_i) begin
      fin_q <= 1'b0;
      if (!rx.listen) begin
        receiving_q <= 1'b0;
      end else if (receiving_q) begin
        bit_cnt_q <= bit_cnt_q + 8'd1;
        if (in_crc_span) crc_q <= crc7_next(crc_q, cmd_i);
        if (is_end) begin
          receiving_q <= 1'b0;
          fin_q       <= 1'b1;
          end_err_q   <= ~cmd_i;
          crc_ok_q    <= (crc_rx_q == crc_q);
        end
      end else if (start_seen) begin
        receiving_q <= 1'b1;
        bit_cnt_q   <= 8'd1;
        crc_q       <= '0;  // a zero start bit leaves the crc at zero
      end
    end
  end

  //////////////////////////////
  // payload

  always_ff @(posedge clk_i) begin
    if (clk_en_p_i) begin
      if (start_seen) begin
        sh_q <= '0;
      end else if (rx.listen && receiving_q) begin
        if (in_body) begin
          sh_q <= {sh_q[118:0], cmd_i};  // older bits fall off the top for R2
        end else if (!is_end) begin
          crc_rx_q <= {crc_rx_q[5:0], cmd_i};
        end
      end
    end
  end

  assign rx.receiving   = receiving_q;
  assign rx.valid       = fin_q & clk_en_p_i;
  assign rx.end_bit_err = end_err_q;
  assign rx.crc_ok      = crc_ok_q;
  assign rx.data        = sh_q;

  // the sequencer must still be listening when the result arrives
  a_valid_listen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx.valid |-> rx.listen);

endmodule

//--- src.f
rtl/sd_cmd_pkg.sv
rtl/sd_cmd_ifs.sv
rtl/sd_clk_gen.sv
rtl/sd_cmd_write.sv
rtl/sd_rsp_read.sv
rtl/sd_cmd_wrap.sv
rtl/sd_cmd_top.sv
dv/sd_card_model.sv
dv/sd_cmd_tb.sv
